// ==== rtl/rv_decode_pkg.sv ====
package rv_decode_pkg;

	// Datapath width
	localparam int xlen = 32;

	// Major opcodes, bits [6:0]
	localparam logic [6:0] opcode_lui    = 7'b0110111;
	localparam logic [6:0] opcode_auipc  = 7'b0010111;
	localparam logic [6:0] opcode_jal    = 7'b1101111;
	localparam logic [6:0] opcode_jalr   = 7'b1100111;
	localparam logic [6:0] opcode_branch = 7'b1100011;
	localparam logic [6:0] opcode_load   = 7'b0000011;
	localparam logic [6:0] opcode_store  = 7'b0100011;
	localparam logic [6:0] opcode_itype  = 7'b0010011;
	localparam logic [6:0] opcode_rtype  = 7'b0110011;
	localparam logic [6:0] opcode_fence  = 7'b0001111;
	// ECALL, EBREAK and the Zicsr forms
	localparam logic [6:0] opcode_system = 7'b1110011;

	// SRLI / SRAI share this funct3
	localparam logic [2:0] itype_srxi = 3'b101;

	// Zicsr funct3 codes
	localparam logic [2:0] csr_csrrw  = 3'b001;
	localparam logic [2:0] csr_csrrs  = 3'b010;
	localparam logic [2:0] csr_csrrc  = 3'b011;
	localparam logic [2:0] csr_csrrwi = 3'b101;
	localparam logic [2:0] csr_csrrsi = 3'b110;
	localparam logic [2:0] csr_csrrci = 3'b111;

	// ALU operand A source
	typedef enum logic [1:0] {
		alu_src_a_none = 2'd0,
		alu_src_a_pc   = 2'd1,
		alu_src_a_rd1  = 2'd2,
		alu_src_a_rs1  = 2'd3
	} alu_src_a_e;

	// ALU operand B source
	typedef enum logic [2:0] {
		alu_src_b_none  = 3'd0,
		alu_src_b_imm   = 3'd1,
		alu_src_b_rd2   = 3'd2,
		alu_src_b_shamt = 3'd3,
		alu_src_b_csr   = 3'd4
	} alu_src_b_e;

	// Register file write data source, used in writeback
	typedef enum logic [2:0] {
		rf_wd_none = 3'd0,
		rf_wd_alu  = 3'd1,
		rf_wd_lui  = 3'd2,
		rf_wd_jump = 3'd3,
		rf_wd_load = 3'd4,
		rf_wd_csr  = 3'd5
	} rf_wd_e;

	// One instruction word, six format views
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm_11_0;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_11_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_4_0;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm_31_12;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} instr_word_u;

endpackage

// ==== rtl/decode_ctrl_if.sv ====
`timescale 1ns/1ps

interface decode_ctrl_if import rv_decode_pkg::*; ();
	logic       jump;
	logic       branch;
	alu_src_a_e alu_src_a_select;
	alu_src_b_e alu_src_b_select;
	logic       csr_write_enable;
	logic       rf_write;
	rf_wd_e     rf_wd_select;
	logic       mem_read;
	logic       mem_write;
	// Opcode not in the decode table
	logic       illegal;

	// Driven by the control unit
	modport control (output jump, branch, alu_src_a_select, alu_src_b_select,
		csr_write_enable, rf_write, rf_wd_select, mem_read, mem_write, illegal);

	// Operand muxes only need the two selects
	modport sel (input alu_src_a_select, alu_src_b_select);

	// Levels captured in the decode/execute register
	modport stage (input jump, branch, csr_write_enable, rf_write, rf_wd_select,
		mem_read, mem_write, illegal);
endinterface

// ==== rtl/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder import rv_decode_pkg::*; (
	input  instr_word_u     instr,
	output logic [6:0]      opcode,
	output logic [2:0]      funct3,
	output logic [4:0]      rd,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output logic [xlen-1:0] imm
);

	// Field positions shared by every format that has them
	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign rd     = instr.r.rd;
	assign rs1    = instr.r.rs1;
	assign rs2    = instr.r.rs2;

	always_comb begin
		imm = '0;
		case (opcode)
			// Upper immediates come out already shifted
			opcode_lui, opcode_auipc: begin
				imm = {instr.u.imm_31_12, 12'b0};
			end
			opcode_jal: begin
				imm = {{(xlen-20){instr.j.imm_20}}, instr.j.imm_19_12,
					instr.j.imm_11, instr.j.imm_10_1, 1'b0};
			end
			opcode_branch: begin
				imm = {{(xlen-12){instr.b.imm_12}}, instr.b.imm_11,
					instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
			end
			opcode_store: begin
				imm = {{(xlen-12){instr.s.imm_11_5[6]}}, instr.s.imm_11_5,
					instr.s.imm_4_0};
			end
			// Plain I format, sign-extended 12 bits
			opcode_jalr, opcode_load, opcode_itype, opcode_fence: begin
				imm = {{(xlen-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
			end
			// CSR address, never sign-extended
			opcode_system: begin
				imm = {{(xlen-12){1'b0}}, instr.i.imm_11_0};
			end
			// R type and unknown opcodes carry no immediate
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit import rv_decode_pkg::*; (
	input  logic [6:0]     opcode,
	input  logic [2:0]     funct3,
	input  logic           write_done,
	input  logic           trap_done,
	decode_ctrl_if.control ctrl,
	output logic           pc_stall
);

	// Hold fetch until writeback and trap entry both finish
	assign pc_stall = !write_done || !trap_done;

	always_comb begin
		// Everything idles unless the opcode asks for it
		ctrl.jump             = 1'b0;
		ctrl.branch           = 1'b0;
		ctrl.alu_src_a_select = alu_src_a_none;
		ctrl.alu_src_b_select = alu_src_b_none;
		ctrl.csr_write_enable = 1'b0;
		ctrl.rf_write         = 1'b0;
		ctrl.rf_wd_select     = rf_wd_none;
		ctrl.mem_read         = 1'b0;
		ctrl.mem_write        = 1'b0;
		ctrl.illegal          = 1'b0;

		case (opcode)
			// Immediate goes straight to rd
			opcode_lui: begin
				ctrl.rf_write     = 1'b1;
				ctrl.rf_wd_select = rf_wd_lui;
			end
			// PC plus upper immediate
			opcode_auipc: begin
				ctrl.alu_src_a_select = alu_src_a_pc;
				ctrl.alu_src_b_select = alu_src_b_imm;
				ctrl.rf_write         = 1'b1;
				ctrl.rf_wd_select     = rf_wd_alu;
			end
			// Target is PC + imm, rd gets PC+4
			opcode_jal: begin
				ctrl.jump             = 1'b1;
				ctrl.alu_src_a_select = alu_src_a_pc;
				ctrl.alu_src_b_select = alu_src_b_imm;
				ctrl.rf_write         = 1'b1;
				ctrl.rf_wd_select     = rf_wd_jump;
			end
			// Target is R[rs1] + imm
			opcode_jalr: begin
				ctrl.jump             = 1'b1;
				ctrl.alu_src_a_select = alu_src_a_rd1;
				ctrl.alu_src_b_select = alu_src_b_imm;
				ctrl.rf_write         = 1'b1;
				ctrl.rf_wd_select     = rf_wd_jump;
			end
			// ALU compares the two registers
			opcode_branch: begin
				ctrl.branch           = 1'b1;
				ctrl.alu_src_a_select = alu_src_a_rd1;
				ctrl.alu_src_b_select = alu_src_b_rd2;
			end
			opcode_load: begin
				ctrl.alu_src_a_select = alu_src_a_rd1;
				ctrl.alu_src_b_select = alu_src_b_imm;
				ctrl.rf_write         = 1'b1;
				ctrl.rf_wd_select     = rf_wd_load;
				ctrl.mem_read         = 1'b1;
			end
			opcode_store: begin
				ctrl.alu_src_a_select = alu_src_a_rd1;
				ctrl.alu_src_b_select = alu_src_b_imm;
				ctrl.mem_write        = 1'b1;
			end
			opcode_itype: begin
				ctrl.alu_src_a_select = alu_src_a_rd1;
				// Shifts take only the shamt bits
				ctrl.alu_src_b_select = (funct3 == itype_srxi) ? alu_src_b_shamt
					: alu_src_b_imm;
				ctrl.rf_write         = 1'b1;
				ctrl.rf_wd_select     = rf_wd_alu;
			end
			opcode_rtype: begin
				ctrl.alu_src_a_select = alu_src_a_rd1;
				ctrl.alu_src_b_select = alu_src_b_rd2;
				ctrl.rf_write         = 1'b1;
				ctrl.rf_wd_select     = rf_wd_alu;
			end
			// No-op at this stage
			opcode_fence: begin
			end
			opcode_system: begin
				case (funct3)
					// Register forms, operand from R[rs1]
					csr_csrrw, csr_csrrs, csr_csrrc: begin
						ctrl.csr_write_enable = 1'b1;
						ctrl.alu_src_a_select = alu_src_a_rd1;
						ctrl.rf_write         = 1'b1;
						ctrl.rf_wd_select     = rf_wd_csr;
					end
					// Immediate forms, rs1 field is the uimm
					csr_csrrwi, csr_csrrsi, csr_csrrci: begin
						ctrl.csr_write_enable = 1'b1;
						ctrl.alu_src_a_select = alu_src_a_rs1;
						ctrl.rf_write         = 1'b1;
						ctrl.rf_wd_select     = rf_wd_csr;
					end
					// ECALL / EBREAK, nothing to select
					default: begin
					end
				endcase
				// Set and clear forms need the old CSR value
				if (ctrl.csr_write_enable && funct3 != csr_csrrw && funct3 != csr_csrrwi) begin
					ctrl.alu_src_b_select = alu_src_b_csr;
				end
			end
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file import rv_decode_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	output logic [xlen-1:0] rd1,
	output logic [xlen-1:0] rd2,
	input  logic            wb_we,
	input  logic [4:0]      wb_rd,
	input  logic [xlen-1:0] wb_data
);

	// x0 has no storage
	logic [xlen-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 1; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (wb_we && wb_rd != 5'd0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// No write bypass, same-cycle reads see the old value
	assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== rtl/operand_select.sv ====
`timescale 1ns/1ps

module operand_select import rv_decode_pkg::*; (
	decode_ctrl_if.sel      sel,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] rd1,
	input  logic [xlen-1:0] rd2,
	input  logic [4:0]      rs1,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] csr_rdata,
	output logic [xlen-1:0] src_a,
	output logic [xlen-1:0] src_b
);

	// Source A mux
	always_comb begin
		case (sel.alu_src_a_select)
			alu_src_a_pc:  src_a = pc;
			alu_src_a_rd1: src_a = rd1;
			// CSR uimm lives in the rs1 field
			alu_src_a_rs1: src_a = {{(xlen-5){1'b0}}, rs1};
			default:       src_a = '0;
		endcase
	end

	// Source B mux
	always_comb begin
		case (sel.alu_src_b_select)
			alu_src_b_imm:   src_b = imm;
			alu_src_b_rd2:   src_b = rd2;
			// Low five bits only, drops the SRAI funct7 bit
			alu_src_b_shamt: src_b = {{(xlen-5){1'b0}}, imm[4:0]};
			alu_src_b_csr:   src_b = csr_rdata;
			default:         src_b = '0;
		endcase
	end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import rv_decode_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            instr_valid,
	input  instr_word_u     instr,
	input  logic [xlen-1:0] pc,
	input  logic            write_done,
	input  logic            trap_done,
	input  logic [xlen-1:0] csr_rdata,
	input  logic            wb_we,
	input  logic [4:0]      wb_rd,
	input  logic [xlen-1:0] wb_data,
	output logic            pc_stall,
	output logic            ex_valid,
	output logic            ex_jump,
	output logic            ex_branch,
	output logic            ex_mem_read,
	output logic            ex_mem_write,
	output logic            ex_rf_write,
	output rf_wd_e          ex_rf_wd_select,
	output logic            ex_csr_write,
	output logic            ex_illegal,
	output logic [xlen-1:0] ex_src_a,
	output logic [xlen-1:0] ex_src_b,
	output logic [xlen-1:0] ex_store_data,
	output logic [xlen-1:0] ex_imm,
	output logic [4:0]      ex_rd,
	output logic [2:0]      ex_funct3,
	output logic [xlen-1:0] ex_pc
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [4:0]      rd;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rd1;
	logic [xlen-1:0] rd2;
	logic [xlen-1:0] src_a;
	logic [xlen-1:0] src_b;
	logic            load;

	decode_ctrl_if ctrl_bus ();

	instruction_decoder u_decoder (
		.instr  (instr),
		.opcode (opcode),
		.funct3 (funct3),
		.rd     (rd),
		.rs1    (rs1),
		.rs2    (rs2),
		.imm    (imm)
	);

	control_unit u_control (
		.opcode     (opcode),
		.funct3     (funct3),
		.write_done (write_done),
		.trap_done  (trap_done),
		.ctrl       (ctrl_bus.control),
		.pc_stall   (pc_stall)
	);

	register_file u_regs (
		.clk     (clk),
		.rst     (rst),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd1     (rd1),
		.rd2     (rd2),
		.wb_we   (wb_we),
		.wb_rd   (wb_rd),
		.wb_data (wb_data)
	);

	operand_select u_operands (
		.sel       (ctrl_bus.sel),
		.pc        (pc),
		.rd1       (rd1),
		.rd2       (rd2),
		.rs1       (rs1),
		.imm       (imm),
		.csr_rdata (csr_rdata),
		.src_a     (src_a),
		.src_b     (src_b)
	);

	// Take the instruction only when valid and not stalled
	assign load = instr_valid && !pc_stall;

	// Decode/execute register, anything else becomes an all-zero bubble
	always_ff @(posedge clk) begin
		if (rst || !load) begin
			ex_valid        <= 1'b0;
			ex_jump         <= 1'b0;
			ex_branch       <= 1'b0;
			ex_mem_read     <= 1'b0;
			ex_mem_write    <= 1'b0;
			ex_rf_write     <= 1'b0;
			ex_rf_wd_select <= rf_wd_none;
			ex_csr_write    <= 1'b0;
			ex_illegal      <= 1'b0;
			ex_src_a        <= '0;
			ex_src_b        <= '0;
			ex_store_data   <= '0;
			ex_imm          <= '0;
			ex_rd           <= '0;
			ex_funct3       <= '0;
			ex_pc           <= '0;
		end else begin
			ex_valid        <= 1'b1;
			ex_jump         <= ctrl_bus.jump;
			ex_branch       <= ctrl_bus.branch;
			ex_mem_read     <= ctrl_bus.mem_read;
			ex_mem_write    <= ctrl_bus.mem_write;
			ex_rf_write     <= ctrl_bus.rf_write;
			ex_rf_wd_select <= ctrl_bus.rf_wd_select;
			ex_csr_write    <= ctrl_bus.csr_write_enable;
			ex_illegal      <= ctrl_bus.illegal;
			ex_src_a        <= src_a;
			ex_src_b        <= src_b;
			// Store data is always R[rs2]
			ex_store_data   <= rd2;
			ex_imm          <= imm;
			ex_rd           <= rd;
			ex_funct3       <= funct3;
			ex_pc           <= pc;
		end
	end

endmodule

// ==== test/tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage import rv_decode_pkg::*; ();

	logic            clk;
	logic            rst;
	logic            instr_valid;
	instr_word_u     instr;
	logic [xlen-1:0] pc;
	logic            write_done;
	logic            trap_done;
	logic [xlen-1:0] csr_rdata;
	logic            wb_we;
	logic [4:0]      wb_rd;
	logic [xlen-1:0] wb_data;
	logic            pc_stall;
	logic            ex_valid;
	logic            ex_jump;
	logic            ex_branch;
	logic            ex_mem_read;
	logic            ex_mem_write;
	logic            ex_rf_write;
	rf_wd_e          ex_rf_wd_select;
	logic            ex_csr_write;
	logic            ex_illegal;
	logic [xlen-1:0] ex_src_a;
	logic [xlen-1:0] ex_src_b;
	logic [xlen-1:0] ex_store_data;
	logic [xlen-1:0] ex_imm;
	logic [4:0]      ex_rd;
	logic [2:0]      ex_funct3;
	logic [xlen-1:0] ex_pc;

	// Shadow copy of the register file, x0 stays zero
	logic [xlen-1:0] model_regs [0:31];
	logic [31:0]     lcg_state;

	// Predicted stage contents
	logic [7:0]      exp_flags;
	rf_wd_e          exp_wd;
	logic [xlen-1:0] exp_a;
	logic [xlen-1:0] exp_b;
	logic [xlen-1:0] exp_imm;
	logic [xlen-1:0] exp_store;

	decode_stage dut (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Order: valid, jump, branch, mem_read, mem_write, rf_write, csr_write, illegal
	function automatic logic [7:0] ex_flags();
		return {ex_valid, ex_jump, ex_branch, ex_mem_read, ex_mem_write, ex_rf_write,
			ex_csr_write, ex_illegal};
	endfunction

	// Reference decode straight from the RV32I / Zicsr encodings
	function automatic void predict(input instr_word_u w, input logic [xlen-1:0] pc_v,
		input logic [xlen-1:0] csr_v);
		logic [31:0] raw;
		logic [4:0]  r1;
		logic [4:0]  r2;
		logic [2:0]  f3;
		logic [31:0] imm_i;
		alu_src_a_e  sa;
		alu_src_b_e  sb;
		logic        jmp;
		logic        brn;
		logic        mrd;
		logic        mwr;
		logic        rfw;
		logic        csrw;
		logic        ill;
		raw = w;
		r1 = raw[19:15];
		r2 = raw[24:20];
		f3 = raw[14:12];
		imm_i = {{20{raw[31]}}, raw[31:20]};
		sa = alu_src_a_none;
		sb = alu_src_b_none;
		jmp = 1'b0;
		brn = 1'b0;
		mrd = 1'b0;
		mwr = 1'b0;
		rfw = 1'b0;
		csrw = 1'b0;
		ill = 1'b0;
		exp_wd = rf_wd_none;
		exp_imm = '0;
		case (raw[6:0])
			opcode_lui: begin
				exp_imm = {raw[31:12], 12'b0};
				rfw = 1'b1;
				exp_wd = rf_wd_lui;
			end
			opcode_auipc: begin
				exp_imm = {raw[31:12], 12'b0};
				sa = alu_src_a_pc;
				sb = alu_src_b_imm;
				rfw = 1'b1;
				exp_wd = rf_wd_alu;
			end
			opcode_jal: begin
				exp_imm = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
				jmp = 1'b1;
				rfw = 1'b1;
				sa = alu_src_a_pc;
				sb = alu_src_b_imm;
				exp_wd = rf_wd_jump;
			end
			opcode_jalr: begin
				exp_imm = imm_i;
				jmp = 1'b1;
				rfw = 1'b1;
				sa = alu_src_a_rd1;
				sb = alu_src_b_imm;
				exp_wd = rf_wd_jump;
			end
			// Compare of two registers, B offset scrambled
			opcode_branch: begin
				exp_imm = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
				brn = 1'b1;
				sa = alu_src_a_rd1;
				sb = alu_src_b_rd2;
			end
			opcode_load: begin
				exp_imm = imm_i;
				mrd = 1'b1;
				rfw = 1'b1;
				sa = alu_src_a_rd1;
				sb = alu_src_b_imm;
				exp_wd = rf_wd_load;
			end
			opcode_store: begin
				exp_imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
				mwr = 1'b1;
				sa = alu_src_a_rd1;
				sb = alu_src_b_imm;
			end
			opcode_itype: begin
				exp_imm = imm_i;
				sa = alu_src_a_rd1;
				// SRLI / SRAI
				sb = (f3 == 3'b101) ? alu_src_b_shamt : alu_src_b_imm;
				rfw = 1'b1;
				exp_wd = rf_wd_alu;
			end
			opcode_rtype: begin
				rfw = 1'b1;
				sa = alu_src_a_rd1;
				sb = alu_src_b_rd2;
				exp_wd = rf_wd_alu;
			end
			opcode_fence: begin
				exp_imm = imm_i;
			end
			opcode_system: begin
				// CSR address, zero-extended
				exp_imm = {20'b0, raw[31:20]};
				if (f3[1:0] != 2'b00) begin
					csrw = 1'b1;
					rfw = 1'b1;
					exp_wd = rf_wd_csr;
					// funct3[2] marks the uimm forms
					sa = f3[2] ? alu_src_a_rs1 : alu_src_a_rd1;
					// CSRRW and CSRRWI ignore the old value
					sb = (f3[1:0] == 2'b01) ? alu_src_b_none : alu_src_b_csr;
				end
			end
			default: begin
				ill = 1'b1;
			end
		endcase
		case (sa)
			alu_src_a_pc:  exp_a = pc_v;
			alu_src_a_rd1: exp_a = model_regs[r1];
			alu_src_a_rs1: exp_a = {27'b0, r1};
			default:       exp_a = '0;
		endcase
		case (sb)
			alu_src_b_imm:   exp_b = exp_imm;
			alu_src_b_rd2:   exp_b = model_regs[r2];
			alu_src_b_shamt: exp_b = {27'b0, exp_imm[4:0]};
			alu_src_b_csr:   exp_b = csr_v;
			default:         exp_b = '0;
		endcase
		exp_store = model_regs[r2];
		exp_flags = {1'b1, jmp, brn, mrd, mwr, rfw, csrw, ill};
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_ctrl(input string test, input logic [7:0] exp_lv,
		input rf_wd_e exp_sel, input logic [7:0] act_lv, input rf_wd_e act_sel);
		if (act_lv !== exp_lv || act_sel !== exp_sel) begin
			stop_run($sformatf("ERROR %s: controls expected %b %s actual %b %s", test,
				exp_lv, exp_sel.name(), act_lv, act_sel.name()));
		end
	endtask

	task automatic check_data(input string test, input string what,
		input logic [xlen-1:0] exp_v, input logic [xlen-1:0] act_v);
		if (act_v !== exp_v) begin
			stop_run($sformatf("ERROR %s: %s expected %h actual %h", test, what, exp_v, act_v));
		end
	endtask

	task automatic check_idx(input string test, input logic [4:0] exp_v,
		input logic [4:0] act_v);
		if (act_v !== exp_v) begin
			stop_run($sformatf("ERROR %s: rd expected %0d actual %0d", test, exp_v, act_v));
		end
	endtask

	task automatic check_stage(input string test, input instr_word_u w,
		input logic [xlen-1:0] pc_v);
		check_ctrl(test, exp_flags, exp_wd, ex_flags(), ex_rf_wd_select);
		check_data(test, "src_a", exp_a, ex_src_a);
		check_data(test, "src_b", exp_b, ex_src_b);
		check_data(test, "imm", exp_imm, ex_imm);
		check_data(test, "store_data", exp_store, ex_store_data);
		check_data(test, "pc", pc_v, ex_pc);
		check_data(test, "funct3", {29'b0, w[14:12]}, {29'b0, ex_funct3});
		check_idx(test, w[11:7], ex_rd);
	endtask

	// Bubble: nothing valid, all controls and data zero
	task automatic check_bubble(input string test);
		check_ctrl(test, 8'h00, rf_wd_none, ex_flags(), ex_rf_wd_select);
		check_data(test, "src_a", '0, ex_src_a);
		check_data(test, "src_b", '0, ex_src_b);
		check_data(test, "imm", '0, ex_imm);
		check_data(test, "store_data", '0, ex_store_data);
		check_data(test, "pc", '0, ex_pc);
		check_data(test, "funct3", '0, {29'b0, ex_funct3});
		check_idx(test, 5'd0, ex_rd);
	endtask

	task automatic wait_ex_valid(input string test);
		int cycles;
		cycles = 0;
		while (ex_valid !== 1'b1) begin
			if (cycles == 20) begin
				stop_run($sformatf("Timeout in %s: ex_valid did not rise in 20 cycles", test));
			end else begin
				@(posedge clk);
				#1;
				cycles++;
			end
		end
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [xlen-1:0] data);
		wb_we = 1'b1;
		wb_rd = idx;
		wb_data = data;
		@(posedge clk);
		#1;
		wb_we = 1'b0;
		if (idx != 5'd0) begin
			model_regs[idx] = data;
		end
	endtask

	// Random word with the chosen opcode and funct3, held for one cycle
	task automatic run_instr(input string test, input logic [6:0] op, input logic [2:0] f3,
		input logic zero_srcs);
		instr_word_u     w;
		logic [xlen-1:0] pc_v;
		w = next_rand();
		w.r.opcode = op;
		w.r.funct3 = f3;
		if (zero_srcs) begin
			w.r.rs1 = 5'd0;
			w.r.rs2 = 5'd0;
		end
		pc_v = next_rand() & 32'hffff_fffc;
		csr_rdata = next_rand();
		predict(w, pc_v, csr_rdata);
		instr = w;
		pc = pc_v;
		instr_valid = 1'b1;
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		wait_ex_valid(test);
		check_stage(test, w, pc_v);
	endtask

	// Reset must win over a valid instruction
	task automatic test_reset();
		instr = 32'h1234_5037;
		instr_valid = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#1;
			check_bubble("reset");
		end
		rst = 1'b0;
		instr_valid = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#1;
			check_bubble("after_reset");
		end
	endtask

	task automatic test_alu_ops();
		run_instr("lui", opcode_lui, 3'(next_rand() >> 29), 1'b0);
		run_instr("auipc", opcode_auipc, 3'(next_rand() >> 29), 1'b0);
		for (int f = 0; f < 8; f++) begin
			run_instr($sformatf("itype_f3_%0d", f), opcode_itype, f[2:0], 1'b0);
			run_instr($sformatf("rtype_f3_%0d", f), opcode_rtype, f[2:0], 1'b0);
		end
	endtask

	task automatic test_mem_flow();
		repeat (4) begin
			run_instr("load", opcode_load, 3'b010, 1'b0);
			run_instr("store", opcode_store, 3'b010, 1'b0);
			run_instr("branch", opcode_branch, 3'(next_rand() >> 29), 1'b0);
			run_instr("jal", opcode_jal, 3'(next_rand() >> 29), 1'b0);
			run_instr("jalr", opcode_jalr, 3'b000, 1'b0);
		end
	endtask

	// funct3 0 is ECALL / EBREAK, the rest are the CSR forms
	task automatic test_csr();
		for (int f = 0; f < 8; f++) begin
			run_instr($sformatf("system_f3_%0d", f), opcode_system, f[2:0], 1'b0);
		end
	endtask

	task automatic test_stall();
		instr_word_u w;
		w = next_rand();
		w.r.opcode = opcode_rtype;
		predict(w, 32'h0000_1000, csr_rdata);
		write_done = 1'b0;
		instr = w;
		pc = 32'h0000_1000;
		instr_valid = 1'b1;
		#1;
		if (pc_stall !== 1'b1) begin
			stop_run("pc_stall stayed low while write_done was low");
		end
		@(posedge clk);
		#1;
		check_bubble("stall_write_done");
		write_done = 1'b1;
		trap_done = 1'b0;
		#1;
		if (pc_stall !== 1'b1) begin
			stop_run("pc_stall stayed low while trap_done was low");
		end
		@(posedge clk);
		#1;
		check_bubble("stall_trap_done");
		trap_done = 1'b1;
		#1;
		if (pc_stall !== 1'b0) begin
			stop_run("pc_stall stayed high after write_done and trap_done rose");
		end
		// Upstream still holds the same instruction
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		wait_ex_valid("stall_resume");
		check_stage("stall_resume", w, 32'h0000_1000);
	endtask

	task automatic test_illegal_x0();
		run_instr("unknown_0x00", 7'h00, 3'b000, 1'b0);
		run_instr("unknown_0x7f", 7'h7f, 3'b111, 1'b0);
		run_instr("unknown_amo", 7'b0101111, 3'b010, 1'b0);
		// x0 was written with a nonzero value and must still read zero
		run_instr("x0_rtype", opcode_rtype, 3'b000, 1'b1);
		run_instr("x0_store", opcode_store, 3'b010, 1'b1);
		run_instr("x0_csrrs", opcode_system, csr_csrrs, 1'b1);
	endtask

	initial begin
		int k;
		lcg_state = 32'he48612c5;
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		write_done = 1'b1;
		trap_done = 1'b1;
		csr_rdata = '0;
		wb_we = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		for (k = 0; k < 32; k++) begin
			model_regs[k] = '0;
		end
		test_reset();
		// Fill the register file, then try to corrupt x0
		for (k = 1; k < 32; k++) begin
			write_reg(k[4:0], next_rand());
		end
		write_reg(5'd0, 32'hdead_beef);
		test_alu_ops();
		test_mem_flow();
		test_csr();
		test_stall();
		test_illegal_x0();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== tb.f ====
rtl/rv_decode_pkg.sv
rtl/decode_ctrl_if.sv
rtl/instruction_decoder.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/operand_select.sv
rtl/decode_stage.sv
test/tb_decode_stage.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_decode_stage
FILELIST = tb.f
BUILD    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
